/* hw/mips_isa_pkg.sv */
package mips_isa_pkg;

    // major opcodes of the supported subset.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // r-type function codes.
    typedef enum logic [5:0] {
        F_JR   = 6'h08,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    // the low half is either r-type fields or the 16-bit immediate.
    typedef union packed {
        r_fields_t   r;
        logic [15:0] imm16;
    } instr_lo_t;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        instr_lo_t  lo;
    } instr_t;

    typedef struct packed {
        alu_op_e alu_op;
        logic    b_is_imm;
        logic    imm_zero_ext;
        logic    reg_write;
        logic    dst_is_rt;
        logic    mem_read;
        logic    mem_write;
        logic    is_branch;
        logic    branch_ne;
        logic    is_jr;
    } ctrl_t;

    // unknown encodings decode to a nop.
    function automatic ctrl_t decode(instr_t i);
        ctrl_t c;
        c = '0;
        case (i.opcode)
            OP_SPECIAL: begin
                c.reg_write = 1'b1;
                case (i.lo.r.funct)
                    F_ADDU:  c.alu_op = ALU_ADD;
                    F_SUBU:  c.alu_op = ALU_SUB;
                    F_AND:   c.alu_op = ALU_AND;
                    F_OR:    c.alu_op = ALU_OR;
                    F_SLT:   c.alu_op = ALU_SLT;
                    F_JR: begin
                        c.reg_write = 1'b0;
                        c.is_jr = 1'b1;
                    end
                    default: c.reg_write = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                c.b_is_imm = 1'b1;
                c.reg_write = 1'b1;
                c.dst_is_rt = 1'b1;
            end
            OP_LUI: begin
                c.alu_op = ALU_LUI;
                c.b_is_imm = 1'b1;
                c.imm_zero_ext = 1'b1;
                c.reg_write = 1'b1;
                c.dst_is_rt = 1'b1;
            end
            OP_BEQ: c.is_branch = 1'b1;
            OP_BNE: begin
                c.is_branch = 1'b1;
                c.branch_ne = 1'b1;
            end
            OP_LW: begin
                c.b_is_imm = 1'b1;
                c.reg_write = 1'b1;
                c.dst_is_rt = 1'b1;
                c.mem_read = 1'b1;
            end
            OP_SW: begin
                c.b_is_imm = 1'b1;
                c.mem_write = 1'b1;
            end
            default: c = '0;
        endcase
        return c;
    endfunction

endpackage

/* hw/avalon_pkg.sv */
package avalon_pkg;

    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;

    // master side of an avalon-mm transfer, held until waitrequest is low.
    typedef struct packed {
        logic [ADDR_W-1:0]   address;
        logic                read;
        logic                write;
        logic [DATA_W-1:0]   writedata;
        logic [DATA_W/8-1:0] byteenable;
    } avalon_req_t;

endpackage

/* hw/cpu_control_fsm.sv */
module cpu_control_fsm
    import mips_isa_pkg::*;
    import avalon_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              waitrequest,
    input  logic [DATA_W-1:0] readdata,
    input  logic [31:0]       pc,
    input  logic [31:0]       alu_result,
    input  logic [31:0]       rt_data,
    input  logic              halting,
    output avalon_req_t       bus,
    output instr_t            instr,
    output ctrl_t             ctrl,
    output logic              ir_load,
    output logic              pc_advance,
    output logic              reg_we,
    output logic              load_sel,
    output logic              active
);

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM,
        DONE
    } state_e;

    state_e state;
    logic   fetch_armed;
    logic   mem_access;

    // keeps the bus idle for the first cycle out of reset.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_armed <= 1'b0;
        end else begin
            fetch_armed <= 1'b1;
        end
    end

    assign mem_access = ctrl.mem_read | ctrl.mem_write;
    assign ir_load    = (state == FETCH) && fetch_armed && !waitrequest;
    assign load_sel   = (state == MEM);
    assign active     = (state != DONE);

    // alu ops retire in exec, loads and stores when the data transfer ends.
    assign pc_advance = ((state == EXEC) && !mem_access) || ((state == MEM) && !waitrequest);
    assign reg_we = ((state == EXEC) && ctrl.reg_write && !ctrl.mem_read)
                 || ((state == MEM) && ctrl.mem_read && !waitrequest);

    always_comb begin
        bus = '0;
        bus.byteenable = '1;
        case (state)
            FETCH: begin
                bus.read    = fetch_armed;
                bus.address = pc;
            end
            MEM: begin
                bus.read      = ctrl.mem_read;
                bus.write     = ctrl.mem_write;
                bus.address   = alu_result;
                bus.writedata = rt_data;
            end
            default: bus.read = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= FETCH;
            ctrl  <= '0;
        end else begin
            case (state)
                FETCH: begin
                    if (ir_load) begin
                        ctrl  <= decode(instr_t'(readdata));
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (mem_access) begin
                        state <= MEM;
                    end else begin
                        state <= halting ? DONE : FETCH;
                    end
                end
                MEM: begin
                    if (!waitrequest) begin
                        state <= halting ? DONE : FETCH;
                    end
                end
                default: state <= DONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ir_load) begin
            instr <= instr_t'(readdata);
        end
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(bus.read && bus.write));

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (bus.read || bus.write) && waitrequest |=> $stable(bus));

    // once stopped, only a reset starts the cpu again.
    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        !active |=> !active);

endmodule

/* hw/pc_sequencer.sv */
module pc_sequencer #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0004
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pc_advance,
    input  logic        branch_taken,
    input  logic        is_jr,
    input  logic [31:0] branch_target,
    output logic [31:0] pc,
    output logic        halting
);

    logic [31:0] pending_pc;
    logic        pending_valid;
    logic        halt_pending;
    logic        redirect;

    assign redirect = branch_taken | is_jr;

    // the delay slot runs from pc + 4, the target is applied one advance later.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc            <= RESET_VECTOR;
            pending_valid <= 1'b0;
            halt_pending  <= 1'b0;
        end else if (pc_advance) begin
            pc            <= pending_valid ? pending_pc : pc + 32'd4;
            pending_valid <= redirect;
            halt_pending  <= is_jr && (branch_target == 32'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (pc_advance && redirect) begin
            pending_pc <= branch_target;
        end
    end

    // high while the delay slot of jr to zero is in flight, so it is the last one.
    assign halting = halt_pending;

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00);

endmodule

/* hw/register_file.sv */
module register_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        we,
    input  logic [4:0]  ra,
    input  logic [4:0]  rb,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    output logic [31:0] v0
);

    logic [31:0] regs [32];

    // $zero is never written, so it reads back as zero after reset.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != 5'd0)) begin
            regs[wa] <= wd;
        end
    end

    assign rs_data = regs[ra];
    assign rt_data = regs[rb];

    // v0 is register 2.
    assign v0 = regs[2];

endmodule

/* hw/alu_branch_unit.sv */
module alu_branch_unit
    import mips_isa_pkg::*;
(
    input  ctrl_t       ctrl,
    input  instr_t      instr,
    input  logic [31:0] pc,
    input  logic [31:0] rs_data,
    input  logic [31:0] rt_data,
    output logic [31:0] result,
    output logic        branch_taken,
    output logic [31:0] branch_target
);

    logic [31:0] imm_sext;
    logic [31:0] imm_ext;
    logic [31:0] op_b;
    logic        rs_eq_rt;

    assign imm_sext = {{16{instr.lo.imm16[15]}}, instr.lo.imm16};
    assign imm_ext  = ctrl.imm_zero_ext ? {16'd0, instr.lo.imm16} : imm_sext;
    assign op_b     = ctrl.b_is_imm ? imm_ext : rt_data;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: result = rs_data + op_b;
            ALU_SUB: result = rs_data - op_b;
            ALU_AND: result = rs_data & op_b;
            ALU_OR:  result = rs_data | op_b;
            ALU_SLT: result = {31'd0, $signed(rs_data) < $signed(op_b)};
            ALU_LUI: result = {op_b[15:0], 16'd0};
            default: result = rs_data + op_b;
        endcase
    end

    assign rs_eq_rt     = (rs_data == rt_data);
    assign branch_taken = ctrl.is_branch && (rs_eq_rt != ctrl.branch_ne);

    // offset is relative to the delay slot address.
    assign branch_target = ctrl.is_jr ? rs_data : pc + 32'd4 + {imm_sext[29:0], 2'b00};

endmodule

/* hw/mips_cpu_top.sv */
module mips_cpu_top
    import mips_isa_pkg::*;
    import avalon_pkg::*;
#(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0004
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              waitrequest,
    input  logic [DATA_W-1:0] readdata,
    output avalon_req_t       bus,
    output logic              active,
    output logic [31:0]       register_v0
);

    instr_t      instr;
    ctrl_t       ctrl;
    logic        pc_advance;
    logic        reg_we;
    logic        load_sel;
    logic [31:0] pc;
    logic        halting;
    logic [31:0] alu_result;
    logic        branch_taken;
    logic [31:0] branch_target;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [4:0]  wa;
    logic [31:0] wd;

    assign wa = ctrl.dst_is_rt ? instr.rt : instr.lo.r.rd;
    assign wd = load_sel ? readdata : alu_result;

    cpu_control_fsm u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .pc          (pc),
        .alu_result  (alu_result),
        .rt_data     (rt_data),
        .halting     (halting),
        .bus         (bus),
        .instr       (instr),
        .ctrl        (ctrl),
        .ir_load     (),
        .pc_advance  (pc_advance),
        .reg_we      (reg_we),
        .load_sel    (load_sel),
        .active      (active)
    );

    pc_sequencer #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_pc (
        .clk           (clk),
        .rst_n         (rst_n),
        .pc_advance    (pc_advance),
        .branch_taken  (branch_taken),
        .is_jr         (ctrl.is_jr),
        .branch_target (branch_target),
        .pc            (pc),
        .halting       (halting)
    );

    register_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (reg_we),
        .ra      (instr.rs),
        .rb      (instr.rt),
        .wa      (wa),
        .wd      (wd),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

    alu_branch_unit u_alu (
        .ctrl          (ctrl),
        .instr         (instr),
        .pc            (pc),
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .result        (alu_result),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

endmodule

/* bench/avalon_ram_model.sv */
module avalon_ram_model
    import avalon_pkg::*;
#(
    parameter int WORDS = 512
) (
    input  logic              clk,
    input  logic              rst_n,
    input  avalon_req_t       bus,
    input  logic [1:0]        stall_len,
    output logic              waitrequest,
    output logic [DATA_W-1:0] readdata,
    input  logic              load_en,
    input  logic [ADDR_W-1:0] load_addr,
    input  logic [DATA_W-1:0] load_data,
    input  logic [ADDR_W-1:0] peek_addr,
    output logic [DATA_W-1:0] peek_data
);

    localparam int AW = $clog2(WORDS);

    logic [DATA_W-1:0] mem [WORDS];
    logic              req;
    logic              busy;
    logic [1:0]        remaining;

    assign req = bus.read | bus.write;

    // a new transfer takes its stall count from stall_len, a running one from the counter.
    assign waitrequest = req && (busy ? (remaining != 2'd0) : (stall_len != 2'd0));

    assign readdata  = mem[bus.address[AW+1:2]];
    assign peek_data = mem[peek_addr[AW+1:2]];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            remaining <= 2'd0;
        end else if (req && waitrequest) begin
            busy      <= 1'b1;
            remaining <= (busy ? remaining : stall_len) - 2'd1;
        end else begin
            busy <= 1'b0;
        end
    end

    // the load port wins, bus writes land on the edge that ends the transfer.
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[AW+1:2]] <= load_data;
        end else if (rst_n && bus.write && !waitrequest) begin
            mem[bus.address[AW+1:2]] <= bus.writedata;
        end
    end

endmodule

/* bench/cpu_tb.sv */
module cpu_tb
    import mips_isa_pkg::*;
    import avalon_pkg::*;
();

    localparam int BODY_MAX    = 24;
    localparam int NUM_TESTS   = 9;
    localparam int DATA_BASE   = 'h400;
    localparam int DATA_WORDS  = 64;
    // the reset test runs its program twice.
    localparam int CYCLE_LIMIT = 40 * (BODY_MAX + 2) * (NUM_TESTS + 1);

    logic              clk;
    logic              rst_n;
    logic              waitrequest;
    logic [DATA_W-1:0] readdata;
    avalon_req_t       bus;
    logic              active;
    logic [31:0]       register_v0;
    logic [1:0]        stall_len;
    logic              stall_on;
    logic              load_en;
    logic [31:0]       load_addr;
    logic [31:0]       load_data;
    logic [31:0]       peek_addr;
    logic [31:0]       peek_data;

    logic [31:0] prog [BODY_MAX + 2];
    logic [31:0] data_init [DATA_WORDS];
    logic [31:0] m_regs [32];
    logic [31:0] m_mem [DATA_WORDS];
    logic [31:0] prog_rng;
    logic [31:0] stall_rng = ~32'd37135;
    int          prog_len;
    int          cycles = 0;
    int          errors;
    int          passed;
    int          failed;
    int          errors_before;
    string       test_name;

    mips_cpu_top #(
        .RESET_VECTOR (32'h0000_0004)
    ) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .bus         (bus),
        .active      (active),
        .register_v0 (register_v0)
    );

    avalon_ram_model #(
        .WORDS (512)
    ) ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (bus),
        .stall_len   (stall_len),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .peek_addr   (peek_addr),
        .peek_data   (peek_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand_prog();
        prog_rng = lcg(prog_rng);
        return prog_rng;
    endfunction

    // new stall length for whatever transfer starts in this cycle.
    always @(posedge clk) begin
        #1;
        stall_rng = lcg(stall_rng);
        stall_len = stall_on ? stall_rng[31:30] : 2'd0;
    end

    always @(negedge clk) begin
        if (rst_n && active) begin
            cycles++;
        end
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: cpu still active after %0d running cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at time %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // every transfer moves a whole word.
    always @(negedge clk) begin
        if (rst_n && (bus.read || bus.write)) begin
            check({28'd0, bus.byteenable}, 32'h0000_000f, "byteenable");
        end
    end

    function automatic logic [31:0] enc_i(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_r(funct_e f, logic [4:0] rs, logic [4:0] rt,
                                          logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'd0, f};
    endfunction

    task automatic fill_data(input logic [31:0] salt);
        for (int k = 0; k < DATA_WORDS; k++) begin
            data_init[k] = (32'(DATA_BASE + 4 * k) * 32'h9e37_79b1) ^ salt;
        end
    endtask

    task automatic load_reference();
        prog[0] = enc_i(OP_ADDIU, 5'd0, 5'd8, 16'h0030);
        prog[1] = enc_i(OP_ADDIU, 5'd0, 5'd9, 16'h0070);
        // the taken branch skips the word after its delay slot, which sets v0.
        prog[2] = enc_i(OP_BEQ, 5'd0, 5'd0, 16'd2);
        prog[3] = enc_r(F_ADDU, 5'd8, 5'd9, 5'd2);
        prog[4] = enc_i(OP_ADDIU, 5'd0, 5'd2, 16'h0001);
        prog[5] = enc_i(OP_SW, 5'd0, 5'd2, 16'h0400);
        prog[6] = enc_i(OP_LW, 5'd0, 5'd2, 16'h0400);
        prog[7] = enc_r(F_JR, 5'd0, 5'd0, 5'd0);
        prog[8] = 32'd0;
        prog_len = 9;
        fill_data(32'd0);
    endtask

    // kind 0 is alu only, kind 1 adds branches, kind 2 adds loads and stores.
    task automatic gen_program(input int kind);
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic        prev_branch;
        int          n;
        int          j;
        n = 8 + int'(rand_prog() >> 28);
        prev_branch = 1'b0;
        for (int i = 0; i < n; i++) begin
            r   = rand_prog();
            r2  = rand_prog();
            rs  = {2'b00, r[31:29]};
            rt  = r[16] ? rs : {2'b00, r[28:26]};
            rd  = {2'b00, r[25:23]};
            imm = r2[31:16];
            if (kind == 1 && !prev_branch && i < n - 1 && r[22:20] >= 3'd6) begin
                // target lies between the word after the delay slot and the final jr.
                j = i + 2 + int'(r2[31:16]) % (n - i - 1);
                prog[i] = enc_i(r[19] ? OP_BNE : OP_BEQ, rs, rt, 16'(j - i - 1));
                prev_branch = 1'b1;
            end else if (kind == 2 && r[22:20] >= 3'd5) begin
                imm = 16'(DATA_BASE + 4 * int'(r2[31:26]));
                prog[i] = enc_i(r[19] ? OP_SW : OP_LW, 5'd0, rt, imm);
                prev_branch = 1'b0;
            end else begin
                case (r[19:17])
                    3'd1:    prog[i] = enc_i(OP_LUI, 5'd0, rt, imm);
                    3'd2:    prog[i] = enc_r(F_ADDU, rs, rt, rd);
                    3'd3:    prog[i] = enc_r(F_SUBU, rs, rt, rd);
                    3'd4:    prog[i] = enc_r(F_AND, rs, rt, rd);
                    3'd5:    prog[i] = enc_r(F_OR, rs, rt, rd);
                    3'd6:    prog[i] = enc_r(F_SLT, rs, rt, rd);
                    default: prog[i] = enc_i(OP_ADDIU, rs, rt, imm);
                endcase
                prev_branch = 1'b0;
            end
        end
        prog[n]     = enc_r(F_JR, 5'd0, 5'd0, 5'd0);
        prog[n + 1] = 32'd0;
        prog_len    = n + 2;
        fill_data(rand_prog());
    endtask

    task automatic set_reg(input logic [4:0] idx, input logic [31:0] val);
        if (idx != 5'd0) begin
            m_regs[idx] = val;
        end
    endtask

    // instruction-level interpreter with delay slots that stops after the slot of jr to zero.
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] nxt;
        logic [31:0] idx;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] ea;
        logic        jr_zero;
        logic        last_slot;
        int          steps;
        for (int k = 0; k < 32; k++) m_regs[k] = '0;
        for (int k = 0; k < DATA_WORDS; k++) m_mem[k] = data_init[k];
        pc        = 32'd4;
        npc       = 32'd8;
        last_slot = 1'b0;
        steps     = 0;
        while (steps < 1000) begin
            idx     = (pc - 32'd4) >> 2;
            ins     = prog[idx[4:0]];
            a       = m_regs[ins[25:21]];
            b       = m_regs[ins[20:16]];
            simm    = {{16{ins[15]}}, ins[15:0]};
            ea      = a + simm;
            nxt     = npc + 32'd4;
            jr_zero = 1'b0;
            case (ins[31:26])
                OP_SPECIAL: begin
                    case (ins[5:0])
                        F_ADDU:  set_reg(ins[15:11], a + b);
                        F_SUBU:  set_reg(ins[15:11], a - b);
                        F_AND:   set_reg(ins[15:11], a & b);
                        F_OR:    set_reg(ins[15:11], a | b);
                        F_SLT:   set_reg(ins[15:11], {31'd0, $signed(a) < $signed(b)});
                        F_JR: begin
                            nxt     = a;
                            jr_zero = (a == 32'd0);
                        end
                        default: ;
                    endcase
                end
                OP_ADDIU: set_reg(ins[20:16], ea);
                OP_LUI:   set_reg(ins[20:16], {ins[15:0], 16'd0});
                OP_BEQ:   if (a == b) nxt = npc + (simm << 2);
                OP_BNE:   if (a != b) nxt = npc + (simm << 2);
                OP_LW:    set_reg(ins[20:16], m_mem[ea[7:2]]);
                OP_SW:    m_mem[ea[7:2]] = b;
                default: ;
            endcase
            if (last_slot) break;
            last_slot = jr_zero;
            pc        = npc;
            npc       = nxt;
            steps++;
        end
        if (steps >= 1000) begin
            $display("reference model never reached the final jump to address zero");
            errors++;
        end
    endtask

    // program and data go in while reset is low, then reset stays low two more cycles.
    task automatic reset_and_load();
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        for (int k = 0; k < prog_len + DATA_WORDS; k++) begin
            load_en = 1'b1;
            if (k < prog_len) begin
                load_addr = 32'(4 + 4 * k);
                load_data = prog[k];
            end else begin
                load_addr = 32'(DATA_BASE + 4 * (k - prog_len));
                load_data = data_init[k - prog_len];
            end
            @(posedge clk);
            #1;
        end
        load_en = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        rst_n = 1'b1;
    endtask

    task automatic wait_halt();
        @(negedge clk);
        while (active) @(negedge clk);
    endtask

    task automatic check_memory();
        for (int k = 0; k < DATA_WORDS; k++) begin
            @(posedge clk);
            #1;
            peek_addr = 32'(DATA_BASE + 4 * k);
            @(negedge clk);
            check(peek_data, m_mem[k], $sformatf("data word at %h", peek_addr));
        end
    endtask

    task automatic run_test(input int t);
        if (t == 0) begin
            test_name = "reference program";
            load_reference();
        end else if (t < 3) begin
            test_name = "random alu";
            gen_program(0);
        end else if (t < 5) begin
            test_name = "random branch";
            gen_program(1);
        end else if (t < NUM_TESTS - 1) begin
            test_name = "random load/store";
            gen_program(2);
        end else begin
            test_name = "reset during run";
            gen_program(2);
        end
        stall_on = (t != 0);
        run_model();
        reset_and_load();
        if (t == NUM_TESTS - 1) begin
            repeat (15) @(posedge clk);
            reset_and_load();
            @(negedge clk);
            check({31'd0, active}, 32'd1, "active after reset");
            check({31'd0, bus.read}, 32'd0, "read after reset");
            check({31'd0, bus.write}, 32'd0, "write after reset");
        end
        wait_halt();
        check(register_v0, (t == 0) ? 32'h0000_00a0 : m_regs[2], "register v0");
        if (t >= 5) begin
            check_memory();
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        peek_addr = '0;
        stall_on  = 1'b0;
        prog_rng  = 32'd37135;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            errors_before = errors;
            run_test(t);
            if (errors == errors_before) begin
                passed++;
                $display("test %0d %s: passed", t, test_name);
            end else begin
                failed++;
                $display("test %0d %s: failed", t, test_name);
            end
        end
        $display("tests %0d, passed %0d, failed %0d, mismatches %0d",
                 NUM_TESTS, passed, failed, errors);
        if (failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* build.f */
hw/mips_isa_pkg.sv
hw/avalon_pkg.sv
hw/cpu_control_fsm.sv
hw/pc_sequencer.sv
hw/register_file.sv
hw/alu_branch_unit.sv
hw/mips_cpu_top.sv
bench/avalon_ram_model.sv
bench/cpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module cpu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vcpu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qxF '** PASS **' "$LOG"; then
    exit 0
fi
exit 1
